//--- Bender.yml
package:
  name: exec_unit

sources:
  # Synthesizable execute stage
  - files:
      - hdl/exec_pkg.sv
      - hdl/exec_logical.sv
      - hdl/exec_adder.sv
      - hdl/exec_shifter.sv
      - hdl/exec_unit.sv
  # Testbench, top module tb_exec_unit
  - target: simulation
    files:
      - sim/exec_assertions.sv
      - sim/exec_checker.sv
      - sim/tb_exec_unit.sv

//--- filelist.f
hdl/exec_pkg.sv
hdl/exec_logical.sv
hdl/exec_adder.sv
hdl/exec_shifter.sv
hdl/exec_unit.sv
sim/exec_assertions.sv
sim/exec_checker.sv
sim/tb_exec_unit.sv

//--- hdl/exec_adder.sv
/*
 * Adder unit of the integer execute stage
 * Add, subtract, signed and unsigned set-less-than on one shared adder,
 * result registered in one stage
 */

`timescale 1ns/1ps
`default_nettype none

module exec_adder
    import exec_pkg::*;
#(
    parameter int  XLEN   = XLEN_DEFAULT,
    parameter type rval_t = logic [XLEN-1:0]
) (
    input  logic      clk,
    input  logic      cke,
    input  logic      acceptable,

    // Operation and operands
    input  add_mode_t mode,
    input  logic      imm_en,
    input  rval_t     imm_val,
    input  rval_t     rs1_val,
    input  rval_t     rs2_val,

    // Registered result
    output rval_t     rd_val
);

    // --------------------------------------------------
    // Shared adder
    // --------------------------------------------------

    rval_t           op2;
    rval_t           op2_eff;
    logic            sub_en;
    logic [XLEN:0]   sum;
    logic            carry_out;
    logic            sign;
    logic            overflow;
    logic            lt_signed;
    logic            lt_unsigned;
    rval_t           rd_q;

    assign op2 = imm_en ? imm_val : rs2_val;

    // Everything except plain add subtracts
    assign sub_en = (mode != ADD_ADD);

    // Two's complement subtract, inverted operand plus carry-in
    assign op2_eff = sub_en ? ~op2 : op2;
    assign sum = {1'b0, rs1_val} + {1'b0, op2_eff} + {{XLEN{1'b0}}, sub_en};

    assign carry_out = sum[XLEN];
    assign sign      = sum[XLEN-1];

    // Overflow when both inputs agree in sign and the sum does not
    assign overflow = (rs1_val[XLEN-1] == op2_eff[XLEN-1])
                   && (sign != rs1_val[XLEN-1]);

    // --------------------------------------------------
    // Compare flags
    // --------------------------------------------------

    // Signed less-than from sign corrected by overflow
    assign lt_signed = sign ^ overflow;
    // Unsigned borrow shows up as a missing carry
    assign lt_unsigned = ~carry_out;

    // --------------------------------------------------
    // Stage 0
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (cke && acceptable) begin
            case (mode)
                ADD_ADD,
                ADD_SUB:  rd_q <= sum[XLEN-1:0];
                ADD_SLT:  rd_q <= {{(XLEN-1){1'b0}}, lt_signed};
                ADD_SLTU: rd_q <= {{(XLEN-1){1'b0}}, lt_unsigned};
                default:  rd_q <= 'x;
            endcase
        end
    end

    assign rd_val = rd_q;

endmodule

`default_nettype wire

//--- hdl/exec_logical.sv
/*
 * Logical unit of the integer execute stage
 * XOR, OR or AND of rs1 with rs2 or an immediate, one register stage
 */

`timescale 1ns/1ps
`default_nettype none

module exec_logical
    import exec_pkg::*;
#(
    parameter int  XLEN   = XLEN_DEFAULT,
    parameter type rval_t = logic [XLEN-1:0]
) (
    input  logic        clk,
    input  logic        cke,
    input  logic        acceptable,

    // Operation and operands
    input  logic_mode_t mode,
    input  logic        imm_en,
    input  rval_t       imm_val,
    input  rval_t       rs1_val,
    input  rval_t       rs2_val,

    // Registered result
    output rval_t       rd_val
);

    // --------------------------------------------------
    // Operand select
    // --------------------------------------------------

    rval_t op2;
    rval_t rd_q;

    // Immediate replaces rs2 when enabled
    assign op2 = imm_en ? imm_val : rs2_val;

    // --------------------------------------------------
    // Stage 0
    // --------------------------------------------------

    // No reset on the datapath, holds while stalled
    always_ff @(posedge clk) begin
        if (cke && acceptable) begin
            case (mode)
                LOGIC_XOR: rd_q <= rs1_val ^ op2;
                LOGIC_OR:  rd_q <= rs1_val | op2;
                LOGIC_AND: rd_q <= rs1_val & op2;
                // 2'b01 is not a defined operation
                default:   rd_q <= 'x;
            endcase
        end
    end

    assign rd_val = rd_q;

endmodule

`default_nettype wire

//--- hdl/exec_pkg.sv
/*
 * Integer execute stage shared definitions
 * Unit select and per-unit operation encodings, used by the RTL and
 * the testbench alike
 */

`default_nettype none

package exec_pkg;

    // --------------------------------------------------
    // Data width
    // --------------------------------------------------

    // Default register width, top level may override with 64
    localparam int XLEN_DEFAULT = 32;

    // --------------------------------------------------
    // Unit select
    // --------------------------------------------------

    // Which unit drives rd_val, code 2'b11 unused
    typedef enum logic [1:0] {
        UNIT_ADD   = 2'b00,
        UNIT_LOGIC = 2'b01,
        UNIT_SHIFT = 2'b10
    } unit_sel_t;

    // --------------------------------------------------
    // Per-unit mode encodings
    // --------------------------------------------------

    // Logical ops, 2'b01 is illegal and yields x
    typedef enum logic [1:0] {
        LOGIC_XOR = 2'b00,
        LOGIC_OR  = 2'b10,
        LOGIC_AND = 2'b11
    } logic_mode_t;

    // Adder ops, all four codes legal
    typedef enum logic [1:0] {
        ADD_ADD  = 2'b00,
        ADD_SUB  = 2'b01,
        ADD_SLT  = 2'b10,
        ADD_SLTU = 2'b11
    } add_mode_t;

    // Shifter ops, 2'b11 unused
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00,
        SHIFT_SRL = 2'b01,
        SHIFT_SRA = 2'b10
    } shift_mode_t;

endpackage

`default_nettype wire

//--- hdl/exec_shifter.sv
/*
 * Shifter unit of the integer execute stage
 * Left logical, right logical and right arithmetic shift of rs1,
 * result registered in one stage
 */

`timescale 1ns/1ps
`default_nettype none

module exec_shifter
    import exec_pkg::*;
#(
    parameter int  XLEN   = XLEN_DEFAULT,
    parameter type rval_t = logic [XLEN-1:0]
) (
    input  logic        clk,
    input  logic        cke,
    input  logic        acceptable,

    // Operation and operands
    input  shift_mode_t mode,
    input  logic        imm_en,
    input  rval_t       imm_val,
    input  rval_t       rs1_val,
    input  rval_t       rs2_val,

    // Registered result
    output rval_t       rd_val
);

    // 5 bits for RV32, 6 for RV64
    localparam int SHAMT_W = $clog2(XLEN);

    // --------------------------------------------------
    // Shift amount and results
    // --------------------------------------------------

    rval_t               op2;
    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     sll_res;
    logic [XLEN-1:0]     srl_res;
    logic [XLEN-1:0]     sra_res;
    rval_t               rd_q;

    assign op2   = imm_en ? imm_val : rs2_val;
    // Upper bits of the amount are ignored
    assign shamt = op2[SHAMT_W-1:0];

    assign sll_res = rs1_val << shamt;
    assign srl_res = rs1_val >> shamt;
    // Fill with rs1 sign bit
    assign sra_res = $signed(rs1_val) >>> shamt;

    // --------------------------------------------------
    // Stage 0
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (cke && acceptable) begin
            case (mode)
                SHIFT_SLL: rd_q <= sll_res;
                SHIFT_SRL: rd_q <= srl_res;
                SHIFT_SRA: rd_q <= sra_res;
                // Unused code
                default:   rd_q <= 'x;
            endcase
        end
    end

    assign rd_val = rd_q;

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
/*
 * Integer execute stage top level
 * Runs the adder, logical and shifter units in parallel, pipelines
 * valid and unit select beside them and picks the result one clock later
 */

`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import exec_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cke,
    input  logic            acceptable,

    // Operation
    input  logic            op_valid,
    input  unit_sel_t       unit_sel,
    input  logic [1:0]      mode,
    input  logic            imm_en,
    input  logic [XLEN-1:0] imm_val,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,

    // Result
    output logic [XLEN-1:0] rd_val,
    output logic            rd_valid
);

    // One register value type for every unit
    typedef logic [XLEN-1:0] rval_t;

    // --------------------------------------------------
    // Mode decode
    // --------------------------------------------------

    logic_mode_t logic_mode;
    add_mode_t   add_mode;
    shift_mode_t shift_mode;

    // Same two bits, read per unit
    assign logic_mode = logic_mode_t'(mode);
    assign add_mode   = add_mode_t'(mode);
    assign shift_mode = shift_mode_t'(mode);

    // --------------------------------------------------
    // Units
    // --------------------------------------------------

    rval_t add_rd;
    rval_t logic_rd;
    rval_t shift_rd;

    exec_adder #(
        .XLEN   (XLEN),
        .rval_t (rval_t)
    ) u_adder (
        .clk        (clk),
        .cke        (cke),
        .acceptable (acceptable),
        .mode       (add_mode),
        .imm_en     (imm_en),
        .imm_val    (imm_val),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_val     (add_rd)
    );

    exec_logical #(
        .XLEN   (XLEN),
        .rval_t (rval_t)
    ) u_logical (
        .clk        (clk),
        .cke        (cke),
        .acceptable (acceptable),
        .mode       (logic_mode),
        .imm_en     (imm_en),
        .imm_val    (imm_val),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_val     (logic_rd)
    );

    exec_shifter #(
        .XLEN   (XLEN),
        .rval_t (rval_t)
    ) u_shifter (
        .clk        (clk),
        .cke        (cke),
        .acceptable (acceptable),
        .mode       (shift_mode),
        .imm_en     (imm_en),
        .imm_val    (imm_val),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_val     (shift_rd)
    );

    // --------------------------------------------------
    // Control pipeline
    // --------------------------------------------------

    logic      valid_q;
    unit_sel_t unit_sel_q;

    // Valid is the only reset register in the stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (cke && acceptable) begin
            valid_q <= op_valid;
        end
    end

    // Loads together with the unit results
    always_ff @(posedge clk) begin
        if (cke && acceptable) begin
            unit_sel_q <= unit_sel;
        end
    end

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------

    always_comb begin
        case (unit_sel_q)
            UNIT_ADD:   rd_val = add_rd;
            UNIT_LOGIC: rd_val = logic_rd;
            UNIT_SHIFT: rd_val = shift_rd;
            default:    rd_val = 'x;
        endcase
    end

    assign rd_valid = valid_q;

endmodule

`default_nettype wire

//--- sim/exec_assertions.sv
/*
 * Concurrent checks bound into the execute stage top level
 * Reset clears valid, stalls freeze the outputs, no illegal logical mode
 */

`timescale 1ns/1ps
`default_nettype none

module exec_assertions
    import exec_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cke,
    input  logic            acceptable,
    input  logic            op_valid,
    input  unit_sel_t       unit_sel,
    input  logic [1:0]      mode,
    input  logic [XLEN-1:0] rd_val,
    input  logic            rd_valid
);

    // Count of failed assertions
    int fail_count;

    initial fail_count = 0;

    // --------------------------------------------------
    // Reset and stall
    // --------------------------------------------------

    // Valid drops on the edge after a reset cycle
    a_reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !rd_valid)
        else begin
            fail_count++;
            $error("rd_valid still high one cycle after reset");
        end

    // Stalled cycle leaves valid untouched
    a_stall_holds_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !(cke && acceptable) |=> $stable(rd_valid))
        else begin
            fail_count++;
            $error("rd_valid changed during a stall");
        end

    // Result only defined once a valid op has landed
    a_stall_holds_val: assert property (@(posedge clk) disable iff (!rst_n)
        (!(cke && acceptable) && rd_valid) |=> $stable(rd_val))
        else begin
            fail_count++;
            $error("rd_val changed during a stall");
        end

    // --------------------------------------------------
    // Legal input
    // --------------------------------------------------

    // Code 2'b01 has no logical operation
    a_legal_logic_mode: assert property (@(posedge clk) disable iff (!rst_n)
        (op_valid && unit_sel == UNIT_LOGIC) |-> (mode != 2'b01))
        else begin
            fail_count++;
            $error("illegal logical mode presented with op_valid high");
        end

endmodule

`default_nettype wire

//--- sim/exec_checker.sv
/*
 * Scoreboard for the execute stage
 * Reference model of all three units, compares rd_val and rd_valid
 * one enabled clock after each accepted operation
 */

`timescale 1ns/1ps
`default_nettype none

module exec_checker
    import exec_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cke,
    input  logic            acceptable,
    input  logic            op_valid,
    input  unit_sel_t       unit_sel,
    input  logic [1:0]      mode,
    input  logic            imm_en,
    input  logic [XLEN-1:0] imm_val,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    input  logic [XLEN-1:0] rd_val,
    input  logic            rd_valid,
    output int              error_count,
    output int              checked_count
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0] exp_val;
    logic            exp_valid;
    // Set once the first reset edge is seen
    logic            armed;
    // New valid result due on the outputs
    logic            fresh;

    initial begin
        armed         = 1'b0;
        fresh         = 1'b0;
        error_count   = 0;
        checked_count = 0;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    function automatic logic [XLEN-1:0] expected_result(unit_sel_t u, logic [1:0] m,
                                                        logic [XLEN-1:0] a,
                                                        logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        int              sh;
        // Shift amount is only the low log2(XLEN) bits
        sh = int'(b[SHAMT_W-1:0]);
        r  = 'x;
        case (u)
            UNIT_LOGIC: begin
                case (logic_mode_t'(m))
                    LOGIC_XOR: r = a ^ b;
                    LOGIC_OR:  r = a | b;
                    LOGIC_AND: r = a & b;
                    default:   r = 'x;
                endcase
            end
            UNIT_ADD: begin
                case (add_mode_t'(m))
                    ADD_ADD:  r = a + b;
                    ADD_SUB:  r = a - b;
                    ADD_SLT:  r = ($signed(a) < $signed(b)) ? 'd1 : 'd0;
                    ADD_SLTU: r = (a < b) ? 'd1 : 'd0;
                    default:  r = 'x;
                endcase
            end
            UNIT_SHIFT: begin
                case (shift_mode_t'(m))
                    SHIFT_SLL: r = a << sh;
                    SHIFT_SRL: r = a >> sh;
                    SHIFT_SRA: begin
                        r = a >> sh;
                        // Vacated top bits copy the sign of a
                        if (a[XLEN-1]) begin
                            r = r | ~({XLEN{1'b1}} >> sh);
                        end
                    end
                    default:   r = 'x;
                endcase
            end
            default: r = 'x;
        endcase
        return r;
    endfunction

    // --------------------------------------------------
    // Capture on the enabled edge, compare mid-cycle
    // --------------------------------------------------

    // Expectation simply holds through stalls
    always @(posedge clk) begin
        if (!rst_n) begin
            armed     <= 1'b1;
            exp_valid <= 1'b0;
            fresh     <= 1'b0;
        end else if (cke && acceptable) begin
            exp_val   <= expected_result(unit_sel, mode, rs1_val,
                                         imm_en ? imm_val : rs2_val);
            exp_valid <= op_valid;
            fresh     <= op_valid;
        end else begin
            fresh     <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            if (rd_valid !== exp_valid) begin
                error_count++;
                $display("Error at %0t: rd_valid expected %b actual %b",
                         $time, exp_valid, rd_valid);
            end else if (exp_valid && rd_val !== exp_val) begin
                error_count++;
                $display("Error at %0t: rd_val expected %h actual %h",
                         $time, exp_val, rd_val);
            end
            // Counts results the DUT actually delivered
            if (fresh && rd_valid === 1'b1) begin
                checked_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_exec_unit.sv
/*
 * Testbench for the integer execute stage
 * Seeded random operations under random stalls, scored by exec_checker
 */

`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit
    import exec_pkg::*;
();

    localparam int XLEN         = 32;
    localparam int NUM_OPS      = 2000;
    localparam int ACCEPT_LIMIT = 100;
    localparam int DRAIN_LIMIT  = 20;

    logic            clk;
    logic            rst_n;
    logic            cke;
    logic            acceptable;
    logic            op_valid;
    unit_sel_t       unit_sel;
    logic [1:0]      mode;
    logic            imm_en;
    logic [XLEN-1:0] imm_val;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] rd_val;
    logic            rd_valid;

    int   error_count;
    int   checked_count;
    int   issued_count;
    int   assert_fails;
    int   waited;
    int   seed_dummy;
    logic hung;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    exec_unit #(
        .XLEN (XLEN)
    ) u_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .acceptable (acceptable),
        .op_valid   (op_valid),
        .unit_sel   (unit_sel),
        .mode       (mode),
        .imm_en     (imm_en),
        .imm_val    (imm_val),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_val     (rd_val),
        .rd_valid   (rd_valid)
    );

    exec_checker #(
        .XLEN (XLEN)
    ) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .cke           (cke),
        .acceptable    (acceptable),
        .op_valid      (op_valid),
        .unit_sel      (unit_sel),
        .mode          (mode),
        .imm_en        (imm_en),
        .imm_val       (imm_val),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .rd_val        (rd_val),
        .rd_valid      (rd_valid),
        .error_count   (error_count),
        .checked_count (checked_count)
    );

    bind exec_unit exec_assertions #(
        .XLEN (XLEN)
    ) u_exec_assertions (
        .clk        (clk),
        .rst_n      (rst_n),
        .cke        (cke),
        .acceptable (acceptable),
        .op_valid   (op_valid),
        .unit_sel   (unit_sel),
        .mode       (mode),
        .rd_val     (rd_val),
        .rd_valid   (rd_valid)
    );

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    // Plain random, equal, sign-differing or corner values
    task automatic pick_operands(output logic [XLEN-1:0] a, output logic [XLEN-1:0] b);
        logic [XLEN-1:0] corners [5] = '{'0, 'd1, {1'b0, {(XLEN-1){1'b1}}},
                                         {1'b1, {(XLEN-1){1'b0}}}, '1};
        a = $urandom;
        b = $urandom;
        case ($urandom_range(0, 3))
            1: b = a;
            2: b[XLEN-1] = ~a[XLEN-1];
            3: begin
                a = corners[$urandom_range(0, 4)];
                b = corners[$urandom_range(0, 4)];
            end
            default: ;
        endcase
    endtask

    // Legal codes only, logical skips 2'b01
    function automatic logic [1:0] pick_mode(unit_sel_t u);
        logic [1:0] m;
        case (u)
            UNIT_LOGIC: begin
                m = 2'($urandom_range(0, 2));
                if (m != 2'b00) m = m + 2'd1;
            end
            UNIT_ADD: m = 2'($urandom_range(0, 3));
            default:  m = 2'($urandom_range(0, 2));
        endcase
        return m;
    endfunction

    // Present one op and hold it until an edge with cke and acceptable high
    task automatic issue_op();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              tries;
        logic            taken;
        pick_operands(a, b);
        unit_sel = unit_sel_t'($urandom_range(0, 2));
        mode     = pick_mode(unit_sel);
        op_valid = ($urandom_range(0, 9) != 0);
        imm_en   = $urandom_range(0, 1);
        rs1_val  = a;
        imm_val  = imm_en ? b : $urandom;
        rs2_val  = imm_en ? $urandom : b;
        tries    = 0;
        taken    = 1'b0;
        while (!taken && tries < ACCEPT_LIMIT) begin
            // Each enable low about 20% of cycles
            cke        = ($urandom_range(0, 9) >= 2);
            acceptable = ($urandom_range(0, 9) >= 2);
            @(posedge clk);
            #2;
            taken = cke && acceptable;
            tries++;
        end
        if (!taken) begin
            $display("Timeout: operation not accepted within %0d cycles", ACCEPT_LIMIT);
            hung = 1'b1;
        end else if (op_valid) begin
            issued_count++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        rst_n        = 1'b0;
        cke          = 1'b0;
        acceptable   = 1'b0;
        op_valid     = 1'b0;
        unit_sel     = UNIT_ADD;
        mode         = 2'b00;
        imm_en       = 1'b0;
        imm_val      = '0;
        rs1_val      = '0;
        rs2_val      = '0;
        issued_count = 0;
        waited       = 0;
        hung         = 1'b0;
        seed_dummy   = $urandom(32'hb77c_1059);

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < NUM_OPS && !hung; i++) begin
            issue_op();
        end

        // Idle slots until the last result is scored
        op_valid   = 1'b0;
        cke        = 1'b1;
        acceptable = 1'b1;
        while (!hung && checked_count < issued_count && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!hung && checked_count != issued_count) begin
            $display("Timeout: only %0d of %0d results came out", checked_count, issued_count);
            hung = 1'b1;
        end

        assert_fails = u_exec_unit.u_exec_assertions.fail_count;
        $display("Summary: %0d checker errors, %0d assertion failures, %0d of %0d results",
                 error_count, assert_fails, checked_count, issued_count);
        if (error_count == 0 && assert_fails == 0 && !hung) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
